/* hw/student_pkg.sv */
`default_nettype none

package student_pkg;

  // Peripheral bus
  parameter int BUS_ADDR_W = 8;  // Bits 7..6 slot, bits 5..2 word
  parameter int BUS_DATA_W = 32;

  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_data_t;

  // Audio path
  parameter int SAMPLE_W  = 16;  // Codec sample
  parameter int FIR_OUT_W = 24;  // Filter result and DAC word
  parameter int COEF_FRAC = 15;  // Q15 coefficients

  typedef logic signed [SAMPLE_W-1:0]  sample_t;
  typedef logic signed [FIR_OUT_W-1:0] fir_out_t;

  // Bus decoder FSM
  typedef enum logic {
    MUX_IDLE,  // Ready for a new request
    MUX_RESP   // Device access and response pending
  } mux_state_e;

endpackage

`default_nettype wire

/* hw/student_tlul_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module student_tlul_mux #(
  parameter int NUM_DEV = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Host side
  input  logic                   a_valid_i,
  input  logic                   a_write_i,
  input  student_pkg::bus_addr_t a_addr_i,
  input  student_pkg::bus_data_t a_wdata_i,
  output logic                   a_ready_o,
  output logic                   d_valid_o,
  output student_pkg::bus_data_t d_rdata_o,
  output logic                   d_error_o,
  input  logic                   d_ready_i,
  // Device side
  output logic [NUM_DEV-1:0]     dev_req_o,
  output logic                   dev_write_o,
  output logic [3:0]             dev_word_o,
  output student_pkg::bus_data_t dev_wdata_o,
  input  student_pkg::bus_data_t dev_rdata_i [NUM_DEV]
);

  localparam int AW = student_pkg::BUS_ADDR_W;

  student_pkg::mux_state_e state_q;
  logic                    accept;
  logic [1:0]              slot;
  logic [1:0]              slot_q;
  logic                    pend_q;  // Device read data arrives next cycle
  logic                    d_valid_q;
  logic                    d_error_q;
  student_pkg::bus_data_t  d_rdata_q;
  student_pkg::bus_data_t  sel_rdata;
  logic                    sel_hit;

  assign a_ready_o = (state_q == student_pkg::MUX_IDLE);
  assign accept    = a_valid_i & a_ready_o;
  assign slot      = a_addr_i[AW-1 -: 2];

  // Shared request fields, qualified by the per-device strobe
  assign dev_write_o = a_write_i;
  assign dev_word_o  = a_addr_i[5:2];
  assign dev_wdata_o = a_wdata_i;

  always_comb begin
    for (int i = 0; i < NUM_DEV; i++) begin
      dev_req_o[i] = accept && (slot == 2'(i));
    end
  end

  // Read data of the registered slot, zero for an unused slot
  always_comb begin
    sel_hit   = 1'b0;
    sel_rdata = '0;
    for (int i = 0; i < NUM_DEV; i++) begin
      if (slot_q == 2'(i)) begin
        sel_hit   = 1'b1;
        sel_rdata = dev_rdata_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= student_pkg::MUX_IDLE;
      slot_q    <= '0;
      pend_q    <= 1'b0;
      d_valid_q <= 1'b0;
      d_error_q <= 1'b0;
    end else begin
      case (state_q)
        student_pkg::MUX_IDLE: begin
          if (accept) begin
            state_q <= student_pkg::MUX_RESP;
            slot_q  <= slot;
            pend_q  <= 1'b1;
          end
        end
        student_pkg::MUX_RESP: begin
          if (pend_q) begin
            pend_q    <= 1'b0;
            d_valid_q <= 1'b1;
            d_error_q <= !sel_hit;
          end else if (d_ready_i) begin  // Host takes the response
            d_valid_q <= 1'b0;
            d_error_q <= 1'b0;
            state_q   <= student_pkg::MUX_IDLE;
          end
        end
        default: state_q <= student_pkg::MUX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == student_pkg::MUX_RESP && pend_q) begin
      d_rdata_q <= sel_rdata;  // Held until the next transaction
    end
  end

  assign d_valid_o = d_valid_q;
  assign d_error_o = d_error_q;
  assign d_rdata_o = d_rdata_q;

endmodule

`default_nettype wire

/* hw/student_fir_parallel.sv */
`timescale 1ns/10ps
`default_nettype none

module student_fir_parallel #(
  parameter int NUM_FIR = 8  // Power of two
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Bus
  input  logic                    req_i,
  input  logic                    write_i,
  input  logic [3:0]              word_i,
  input  student_pkg::bus_data_t  wdata_i,
  output student_pkg::bus_data_t  rdata_o,
  // Audio
  input  student_pkg::sample_t    sample_i,
  input  logic                    valid_i,
  output student_pkg::fir_out_t   y_o,
  output logic                    valid_o
);

  localparam int SW     = student_pkg::SAMPLE_W;
  localparam int OW     = student_pkg::FIR_OUT_W;
  localparam int DW     = student_pkg::BUS_DATA_W;
  localparam int PROD_W = 2 * SW;
  localparam int ACC_W  = PROD_W + $clog2(NUM_FIR);

  student_pkg::sample_t     coef_q [NUM_FIR];
  student_pkg::sample_t     hist_q [NUM_FIR-1];  // Older samples, taps 1 and up
  student_pkg::sample_t     taps   [NUM_FIR];    // Delay line after the shift
  logic signed [PROD_W-1:0] prod_q [NUM_FIR];
  logic signed [ACC_W-1:0]  sum;
  logic signed [ACC_W-1:0]  sum_shift;
  logic                     prod_valid_q;
  logic                     valid_q;
  student_pkg::fir_out_t    y_q;
  student_pkg::bus_data_t   rdata_q;

  always_comb begin
    taps[0] = sample_i;  // Tap 0 is the newest sample
    for (int i = 1; i < NUM_FIR; i++) begin
      taps[i] = hist_q[i-1];
    end
  end

  // Pairwise adder tree over the registered products
  always_comb begin
    logic signed [ACC_W-1:0] acc [NUM_FIR];
    for (int i = 0; i < NUM_FIR; i++) begin
      acc[i] = ACC_W'(prod_q[i]);
    end
    for (int w = NUM_FIR / 2; w > 0; w = w / 2) begin
      for (int j = 0; j < w; j++) begin
        acc[j] = acc[2*j] + acc[2*j+1];
      end
    end
    sum = acc[0];
  end

  assign sum_shift = sum >>> student_pkg::COEF_FRAC;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_FIR; i++) begin
        coef_q[i] <= '0;
      end
      for (int i = 0; i < NUM_FIR - 1; i++) begin
        hist_q[i] <= '0;
      end
      prod_valid_q <= 1'b0;
      valid_q      <= 1'b0;
      y_q          <= '0;
    end else begin
      prod_valid_q <= valid_i;
      valid_q      <= prod_valid_q;
      if (valid_i) begin
        for (int i = 0; i < NUM_FIR - 1; i++) begin
          hist_q[i] <= taps[i];
        end
      end
      if (prod_valid_q) begin
        y_q <= sum_shift[OW-1:0];  // Wraps on overflow
      end
      for (int i = 0; i < NUM_FIR; i++) begin
        if (req_i && write_i && word_i == 4'(i)) begin
          coef_q[i] <= wdata_i[SW-1:0];
        end
      end
    end
  end

  // Products and read data
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int i = 0; i < NUM_FIR; i++) begin
        prod_q[i] <= PROD_W'(coef_q[i]) * PROD_W'(taps[i]);
      end
    end
    if (req_i) begin
      rdata_q <= '0;
      if (word_i == 4'd15) begin
        rdata_q <= {{(DW-OW){y_q[OW-1]}}, y_q};  // Last output
      end
      for (int i = 0; i < NUM_FIR; i++) begin
        if (word_i == 4'(i)) begin
          rdata_q <= {{(DW-SW){1'b0}}, coef_q[i]};
        end
      end
    end
  end

  assign y_o     = y_q;
  assign valid_o = valid_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/student_iis_handler.sv */
`timescale 1ns/10ps
`default_nettype none

module student_iis_handler #(
  parameter int BCLK_DIV = 4  // clk_i cycles per bclk half period
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Bus
  input  logic                   req_i,
  input  logic                   write_i,
  input  logic [3:0]             word_i,
  input  student_pkg::bus_data_t wdata_i,
  output student_pkg::bus_data_t rdata_o,
  // Codec
  output logic                   mclk_o,
  output logic                   bclk_o,
  output logic                   lrclk_o,
  input  logic                   adc_sdata_i,
  output logic                   dac_sdata_o,
  // Audio
  output student_pkg::sample_t   adc_sample_o,
  output logic                   adc_valid_o,
  input  student_pkg::fir_out_t  fir_y_i,
  input  logic                   fir_valid_i
);

  localparam int SW    = student_pkg::SAMPLE_W;
  localparam int OW    = student_pkg::FIR_OUT_W;
  localparam int DW    = student_pkg::BUS_DATA_W;
  localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;

  logic                   en_q;
  logic                   mclk_q;
  logic                   bclk_q;
  logic                   dac_q;
  logic                   adc_valid_q;
  logic [DIV_W-1:0]       div_q;
  logic [5:0]             cnt_q;  // Bit slot in frame, MSB selects channel
  logic [5:0]             cnt_nxt;
  logic [4:0]             bit_idx;
  logic [4:0]             bit_nxt;
  logic                   tick;
  logic                   rise;
  logic                   fall;
  student_pkg::bus_data_t frame_q;
  student_pkg::bus_data_t rdata_q;
  student_pkg::sample_t   adc_sample_q;
  logic [SW-1:0]          adc_shift_q;
  student_pkg::fir_out_t  fir_q;
  logic [OW-1:0]          dac_shift_q;

  assign tick    = en_q && (div_q == DIV_W'(BCLK_DIV - 1));
  assign rise    = tick && !bclk_q;
  assign fall    = tick && bclk_q;
  assign cnt_nxt = cnt_q + 6'd1;
  assign bit_idx = cnt_q[4:0];
  assign bit_nxt = cnt_nxt[4:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q         <= 1'b0;
      mclk_q       <= 1'b0;
      bclk_q       <= 1'b0;
      div_q        <= '0;
      cnt_q        <= '0;
      dac_q        <= 1'b0;
      adc_valid_q  <= 1'b0;
      frame_q      <= '0;
      adc_sample_q <= '0;
      fir_q        <= '0;
    end else begin
      adc_valid_q <= 1'b0;
      if (fir_valid_i) begin
        fir_q <= fir_y_i;  // Sent in the next right channel
      end
      if (!en_q) begin
        mclk_q <= 1'b0;
        bclk_q <= 1'b0;
        div_q  <= '0;
        cnt_q  <= '0;
        dac_q  <= 1'b0;
      end else begin
        mclk_q <= ~mclk_q;
        div_q  <= tick ? '0 : div_q + 1'b1;
        if (rise) begin
          bclk_q <= 1'b1;
          if (!cnt_q[5] && bit_idx == 5'(SW)) begin  // Left LSB
            adc_sample_q <= {adc_shift_q[SW-2:0], adc_sdata_i};
            adc_valid_q  <= 1'b1;
          end
        end
        if (fall) begin
          bclk_q <= 1'b0;
          cnt_q  <= cnt_nxt;
          if (cnt_q == '1) begin
            frame_q <= frame_q + 1'b1;
          end
          if (cnt_nxt[5] && bit_nxt >= 5'd1 && bit_nxt <= 5'(OW)) begin
            dac_q <= dac_shift_q[OW-1];
          end else begin
            dac_q <= 1'b0;  // Left channel and idle bits
          end
        end
      end
      if (req_i && write_i && word_i == 4'd0) begin
        en_q <= wdata_i[0];
      end
    end
  end

  // Shift registers and read data
  always_ff @(posedge clk_i) begin
    if (rise && bit_idx >= 5'd1 && bit_idx <= 5'(SW)) begin
      adc_shift_q <= {adc_shift_q[SW-2:0], adc_sdata_i};
    end
    if (fall) begin
      if (cnt_nxt == 6'd32) begin
        dac_shift_q <= fir_q;  // Right channel starts
      end else if (cnt_nxt[5] && bit_nxt >= 5'd1 && bit_nxt <= 5'(OW)) begin
        dac_shift_q <= dac_shift_q << 1;
      end
    end
    if (req_i) begin
      case (word_i)
        4'd0:    rdata_q <= {{(DW-1){1'b0}}, en_q};
        4'd1:    rdata_q <= {{(DW-SW){adc_sample_q[SW-1]}}, adc_sample_q};
        4'd2:    rdata_q <= frame_q;
        default: rdata_q <= '0;
      endcase
    end
  end

  assign mclk_o       = mclk_q;
  assign bclk_o       = bclk_q;
  assign lrclk_o      = cnt_q[5];  // Low for left
  assign dac_sdata_o  = dac_q;
  assign adc_sample_o = adc_sample_q;
  assign adc_valid_o  = adc_valid_q;
  assign rdata_o      = rdata_q;

endmodule

`default_nettype wire

/* hw/student.sv */
`timescale 1ns/10ps
`default_nettype none

module student #(
  parameter int NUM_FIR  = 8,
  parameter int NUM_DEV  = 2,
  parameter int BCLK_DIV = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Host bus
  input  logic                   a_valid_i,
  input  logic                   a_write_i,
  input  student_pkg::bus_addr_t a_addr_i,
  input  student_pkg::bus_data_t a_wdata_i,
  output logic                   a_ready_o,
  output logic                   d_valid_o,
  output student_pkg::bus_data_t d_rdata_o,
  output logic                   d_error_o,
  input  logic                   d_ready_i,
  // Codec
  output logic                   mclk_o,
  output logic                   bclk_o,
  output logic                   lrclk_o,
  input  logic                   adc_sdata_i,
  output logic                   dac_sdata_o
);

  logic [NUM_DEV-1:0]     dev_req;
  logic                   dev_write;
  logic [3:0]             dev_word;
  student_pkg::bus_data_t dev_wdata;
  student_pkg::bus_data_t dev_rdata [NUM_DEV];

  student_pkg::sample_t   adc_sample;
  logic                   adc_valid;
  student_pkg::fir_out_t  fir_y;
  logic                   fir_valid;

  student_tlul_mux #(
    .NUM_DEV(NUM_DEV)
  ) i_tlul_mux (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .a_valid_i  (a_valid_i),
    .a_write_i  (a_write_i),
    .a_addr_i   (a_addr_i),
    .a_wdata_i  (a_wdata_i),
    .a_ready_o  (a_ready_o),
    .d_valid_o  (d_valid_o),
    .d_rdata_o  (d_rdata_o),
    .d_error_o  (d_error_o),
    .d_ready_i  (d_ready_i),
    .dev_req_o  (dev_req),
    .dev_write_o(dev_write),
    .dev_word_o (dev_word),
    .dev_wdata_o(dev_wdata),
    .dev_rdata_i(dev_rdata)
  );

  // Slot 0
  student_fir_parallel #(
    .NUM_FIR(NUM_FIR)
  ) i_fir (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dev_req[0]),
    .write_i (dev_write),
    .word_i  (dev_word),
    .wdata_i (dev_wdata),
    .rdata_o (dev_rdata[0]),
    .sample_i(adc_sample),
    .valid_i (adc_valid),
    .y_o     (fir_y),
    .valid_o (fir_valid)
  );

  // Slot 1
  student_iis_handler #(
    .BCLK_DIV(BCLK_DIV)
  ) i_iis (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (dev_req[1]),
    .write_i     (dev_write),
    .word_i      (dev_word),
    .wdata_i     (dev_wdata),
    .rdata_o     (dev_rdata[1]),
    .mclk_o      (mclk_o),
    .bclk_o      (bclk_o),
    .lrclk_o     (lrclk_o),
    .adc_sdata_i (adc_sdata_i),
    .dac_sdata_o (dac_sdata_o),
    .adc_sample_o(adc_sample),
    .adc_valid_o (adc_valid),
    .fir_y_i     (fir_y),
    .fir_valid_i (fir_valid)
  );

endmodule

`default_nettype wire

/* testbench/student_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module student_assert (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   a_valid_i,
  input logic                   a_ready_i,
  input logic                   d_valid_i,
  input logic                   d_ready_i,
  input logic                   d_error_i,
  input student_pkg::bus_data_t d_rdata_i
);

  int unsigned fail_cnt;  // Count of failed assertions

  // Only one transaction in flight
  busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    a_valid_i && a_ready_i |=> !a_ready_i)
    else begin
      fail_cnt++;
      $error("a_ready_o stayed high after a request was accepted");
    end

  no_accept_in_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_valid_i |-> !a_ready_i)
    else begin
      fail_cnt++;
      $error("a_ready_o high while a response is pending");
    end

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_rdata_i) && $stable(d_error_i))
    else begin
      fail_cnt++;
      $error("Response changed under back-pressure");
    end

  error_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_error_i |-> d_valid_i)
    else begin
      fail_cnt++;
      $error("d_error_o high without d_valid_o");
    end

  rdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_valid_i |-> !$isunknown(d_rdata_i))
    else begin
      fail_cnt++;
      $error("d_rdata_o unknown during a response");
    end

endmodule

bind student_tlul_mux student_assert i_mux_assert (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .a_valid_i(a_valid_i),
  .a_ready_i(a_ready_o),
  .d_valid_i(d_valid_o),
  .d_ready_i(d_ready_i),
  .d_error_i(d_error_o),
  .d_rdata_i(d_rdata_o)
);

`default_nettype wire

/* testbench/student_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module student_tb;

  localparam int NUM_FIR      = 8;
  localparam int NUM_FRAMES   = 12;
  localparam int CLK_PERIOD   = 40;
  localparam int FRAME_CYCLES = 512;
  localparam int WATCHDOG_NS  = (NUM_FRAMES * FRAME_CYCLES + 3000) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h958b_f576;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   a_valid_i;
  logic                   a_write_i;
  student_pkg::bus_addr_t a_addr_i;
  student_pkg::bus_data_t a_wdata_i;
  logic                   a_ready_o;
  logic                   d_valid_o;
  student_pkg::bus_data_t d_rdata_o;
  logic                   d_error_o;
  logic                   d_ready_i;
  logic                   mclk_o;
  logic                   bclk_o;
  logic                   lrclk_o;
  logic                   adc_sdata_i = 1'b0;
  logic                   dac_sdata_o;

  // Q15 coefficients, fixed
  student_pkg::sample_t coef_tbl [NUM_FIR] = '{16'h7fff, 16'h4000, 16'he000, 16'h1000,
                                               16'h8000, 16'h0800, 16'hc000, 16'h0100};
  student_pkg::sample_t  adc_tbl [NUM_FRAMES];  // Left ADC word per frame
  student_pkg::fir_out_t exp_tbl [NUM_FRAMES];  // Expected DAC word per frame
  int                    err_cnt = 0;

  // Codec model state
  int                    bit_pos   = 0;  // Bit slot within the channel
  int                    adc_frame = 0;
  logic                  lr_prev   = 1'b0;
  student_pkg::fir_out_t dac_shift = '0;
  student_pkg::fir_out_t dac_seen [NUM_FRAMES+4];
  int                    dac_count = 0;

  student #(
    .NUM_FIR (NUM_FIR),
    .NUM_DEV (2),
    .BCLK_DIV(4)
  ) i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .a_valid_i  (a_valid_i),
    .a_write_i  (a_write_i),
    .a_addr_i   (a_addr_i),
    .a_wdata_i  (a_wdata_i),
    .a_ready_o  (a_ready_o),
    .d_valid_o  (d_valid_o),
    .d_rdata_o  (d_rdata_o),
    .d_error_o  (d_error_o),
    .d_ready_i  (d_ready_i),
    .mclk_o     (mclk_o),
    .bclk_o     (bclk_o),
    .lrclk_o    (lrclk_o),
    .adc_sdata_i(adc_sdata_i),
    .dac_sdata_o(dac_sdata_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Direct form FIR over the table, zero history before frame 0
  function automatic student_pkg::fir_out_t fir_reference(input int n);
    longint acc;
    acc = 0;
    for (int k = 0; k < NUM_FIR; k++) begin
      if (n - k >= 0) begin
        acc += longint'(coef_tbl[k]) * longint'(adc_tbl[n-k]);
      end
    end
    return student_pkg::fir_out_t'(acc >>> student_pkg::COEF_FRAC);
  endfunction

  function automatic student_pkg::bus_addr_t reg_addr(input logic [1:0] slot, input int word);
    return {slot, word[3:0], 2'b00};
  endfunction

  task automatic build_table();
    logic [31:0] rnd;
    rnd = SEED;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      rnd        = xorshift32(rnd);
      adc_tbl[f] = rnd[15:0];
    end
    adc_tbl[4] = 16'h8000;  // Extremes
    adc_tbl[5] = 16'h7fff;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      exp_tbl[f] = fir_reference(f);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("[FAIL] t=%0t ns %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input student_pkg::bus_data_t got, input student_pkg::bus_data_t exp,
                            input string what);
    if (got !== exp) report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_sample(input student_pkg::sample_t got, input student_pkg::sample_t exp,
                              input string what);
    if (got !== exp) report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_fir(input student_pkg::fir_out_t got, input student_pkg::fir_out_t exp,
                           input string what);
    if (got !== exp) report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_error($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  // One bus transaction, with stall cycles of d_ready_i low
  task automatic bus_xfer(input logic write, input student_pkg::bus_addr_t addr,
                          input student_pkg::bus_data_t wdata, input int stall,
                          output student_pkg::bus_data_t rdata, output logic err);
    int cycles;
    @(posedge clk_i);
    #2;
    a_valid_i = 1'b1;
    a_write_i = write;
    a_addr_i  = addr;
    a_wdata_i = wdata;
    d_ready_i = (stall == 0);
    @(negedge clk_i);
    while (!a_ready_o) @(negedge clk_i);
    @(posedge clk_i);  // Accepted here
    #2;
    a_valid_i = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!d_valid_o);
    check_data(student_pkg::bus_data_t'(cycles), 32'd2, "response latency");
    rdata = d_rdata_o;
    err   = d_error_o;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check_bit(d_valid_o, 1'b1, "d_valid_o under back-pressure");
      check_data(d_rdata_o, rdata, "d_rdata_o under back-pressure");
      check_bit(d_error_o, err, "d_error_o under back-pressure");
    end
    if (stall > 0) begin
      @(posedge clk_i);
      #2;
      d_ready_i = 1'b1;
    end
    @(posedge clk_i);  // Response taken
    @(negedge clk_i);
    check_bit(d_valid_o, 1'b0, "d_valid_o after response");
    check_bit(a_ready_o, 1'b1, "a_ready_o after response");
  endtask

  task automatic check_codec_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit(mclk_o, 1'b0, "mclk_o while disabled");
      check_bit(bclk_o, 1'b0, "bclk_o while disabled");
      check_bit(lrclk_o, 1'b0, "lrclk_o while disabled");
      check_bit(dac_sdata_o, 1'b0, "dac_sdata_o while disabled");
    end
  endtask

  // Master clock runs at half the clk_i rate
  task automatic check_mclk_rate(input int cycles);
    logic prev;
    @(negedge clk_i);
    prev = mclk_o;
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit(mclk_o, ~prev, "mclk_o at half the clock rate");
      prev = mclk_o;
    end
  endtask

  // Codec ADC side, next bit after each falling bclk
  always @(negedge bclk_o) begin
    logic [15:0] adc_word;
    #2;
    if (rst_n_i === 1'b1) begin  // No bit slots before reset ends
      if (lrclk_o != lr_prev) begin
        bit_pos = 0;
        if (!lrclk_o) adc_frame++;  // New frame
      end else begin
        bit_pos++;
      end
      lr_prev = lrclk_o;
      adc_word = '0;
      if (!lrclk_o && bit_pos >= 1 && bit_pos <= student_pkg::SAMPLE_W &&
          adc_frame < NUM_FRAMES) begin
        adc_word = adc_tbl[adc_frame] << (bit_pos - 1);  // MSB first
      end
      adc_sdata_i = adc_word[student_pkg::SAMPLE_W-1];
    end
  end

  // Codec DAC side, right channel only
  always @(posedge bclk_o) begin
    if (lrclk_o && bit_pos >= 1 && bit_pos <= student_pkg::FIR_OUT_W) begin
      dac_shift = {dac_shift[student_pkg::FIR_OUT_W-2:0], dac_sdata_o};
      if (bit_pos == student_pkg::FIR_OUT_W) begin
        if (dac_count < NUM_FRAMES + 4) dac_seen[dac_count] = dac_shift;
        dac_count++;
      end
    end
  end

  initial begin
    student_pkg::bus_data_t rdata;
    logic                   err;
    rst_n_i   = 1'b0;
    a_valid_i = 1'b0;
    a_write_i = 1'b0;
    a_addr_i  = '0;
    a_wdata_i = '0;
    d_ready_i = 1'b1;
    build_table();
    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    check_bit(a_ready_o, 1'b1, "a_ready_o after reset");
    check_bit(d_valid_o, 1'b0, "d_valid_o after reset");
    check_codec_idle(64);

    // Upper half of the write data is dropped
    for (int i = 0; i < NUM_FIR; i++) begin
      bus_xfer(1'b1, reg_addr(2'd0, i), {16'hdead ^ 16'(i), coef_tbl[i]}, 0, rdata, err);
      check_bit(err, 1'b0, "d_error_o on coefficient write");
    end
    for (int i = 0; i < NUM_FIR; i++) begin
      bus_xfer(1'b0, reg_addr(2'd0, i), '0, 0, rdata, err);
      check_data(rdata, {16'h0000, coef_tbl[i]}, "coefficient readback");
      check_bit(err, 1'b0, "d_error_o on coefficient read");
    end

    for (int s = 2; s < 4; s++) begin
      bus_xfer(1'b1, reg_addr(2'(s), 1), 32'h1234_5678, 0, rdata, err);
      check_bit(err, 1'b1, "d_error_o on unused slot write");
      bus_xfer(1'b0, reg_addr(2'(s), 1), '0, 0, rdata, err);
      check_bit(err, 1'b1, "d_error_o on unused slot read");
      check_data(rdata, '0, "read data of unused slot");
    end

    bus_xfer(1'b0, reg_addr(2'd0, 3), '0, 6, rdata, err);
    check_data(rdata, {16'h0000, coef_tbl[3]}, "readback under back-pressure");

    bus_xfer(1'b1, reg_addr(2'd1, 0), 32'h1, 0, rdata, err);  // Enable the handler
    check_mclk_rate(16);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      while (dac_count <= f) @(posedge clk_i);
      check_fir(dac_seen[f], exp_tbl[f], $sformatf("DAC word of frame %0d", f));
      bus_xfer(1'b0, reg_addr(2'd1, 1), '0, 0, rdata, err);
      check_sample(rdata[15:0], adc_tbl[f], "ADC sample readback");
      check_data(rdata, {{16{adc_tbl[f][15]}}, adc_tbl[f]}, "ADC sample sign extension");
      bus_xfer(1'b0, reg_addr(2'd1, 2), '0, 0, rdata, err);
      check_data(rdata, student_pkg::bus_data_t'(f), "frame counter");
      bus_xfer(1'b0, reg_addr(2'd0, 15), '0, 0, rdata, err);
      check_data(rdata, {{8{exp_tbl[f][23]}}, exp_tbl[f]}, "filter word 15");
    end

    bus_xfer(1'b1, reg_addr(2'd1, 0), '0, 0, rdata, err);
    check_codec_idle(64);

    if (err_cnt == 0 && i_dut.i_tlul_mux.i_mux_assert.fail_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "Errors were found");
    end
  end

endmodule

`default_nettype wire

/* tb.f */
hw/student_pkg.sv
hw/student_tlul_mux.sv
hw/student_fir_parallel.sv
hw/student_iis_handler.sv
hw/student.sv
testbench/student_assert.sv
testbench/student_tb.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vstudent_tb: tb.f $(wildcard hw/*.sv testbench/*.sv)
	verilator --binary --timing --assert --top-module student_tb -f tb.f

run: obj_dir/Vstudent_tb
	@out="$$(./obj_dir/Vstudent_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --top-module student_tb -f tb.f

clean:
	rm -rf obj_dir
